// ==== Bender.yml ====
package:
  name: oflow_core

sources:
  - files:
      - rtl/oflow_core_pkg.sv
      - rtl/oflow_reg_pkg.sv
      - rtl/oflow_axil_regs.sv
      - rtl/oflow_core_fsm_fe.sv
      - rtl/oflow_core_fsm_registration.sv
      - rtl/oflow_registration_pe.sv
      - rtl/oflow_core_top.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/oflow_core_tb.sv

// ==== rtl/oflow_axil_regs.sv ====
/*
 * AXI4-Lite register block, one write and one read in flight at a time
 * match bits past num_box are dropped, match map covers 32 boxes
 */
`timescale 1ns/1ns

module oflow_axil_regs #(
	parameter int PE_NUM = 4
) (
	input  logic                     clk,
	input  logic                     reset_N,
	input  oflow_reg_pkg::axil_req_t host_req,
	output oflow_reg_pkg::axil_rsp_t host_rsp,
	output oflow_reg_pkg::cfg_t      cfg,
	input  logic [PE_NUM-1:0]        pe_match,
	input  oflow_core_pkg::set_cnt_t set_index,
	input  logic                     done_registration,
	input  logic                     frame_done
);

	logic              wr_fire;
	logic              rd_fire;
	logic              b_valid;
	logic              r_valid;
	logic [31:0]       r_data;
	logic [31:0]       rd_mux;
	logic              busy;
	logic              done;
	logic [31:0]       match_map;
	logic [5:0]        match_cnt;
	logic [PE_NUM-1:0] set_match;
	logic [5:0]        set_hits;

	// ----------------------------------------------------------------------
	// channel handshakes
	// ----------------------------------------------------------------------

	// aw and w taken together, only with no response pending
	assign wr_fire = host_req.aw_valid && host_req.w_valid && !b_valid;
	assign rd_fire = host_req.ar_valid && !r_valid;

	always_comb begin
		host_rsp          = '0;
		host_rsp.aw_ready = wr_fire;
		host_rsp.w_ready  = wr_fire;
		host_rsp.b_valid  = b_valid;
		host_rsp.ar_ready = !r_valid;
		host_rsp.r_valid  = r_valid;
		host_rsp.r_data   = r_data;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			b_valid <= 1'b0;
			r_valid <= 1'b0;
		end else begin
			// held until the host takes it
			if (wr_fire)
				b_valid <= 1'b1;
			else if (host_req.b_ready)
				b_valid <= 1'b0;
			if (rd_fire)
				r_valid <= 1'b1;
			else if (host_req.r_ready)
				r_valid <= 1'b0;
		end
	end

	// read data mux, unmapped offsets give zero
	always_comb begin
		case (host_req.ar_addr)
			oflow_reg_pkg::ADDR_NUM_BOX:   rd_mux = {26'd0, cfg.num_box};
			oflow_reg_pkg::ADDR_THRESH:    rd_mux = {16'd0, cfg.thresh};
			oflow_reg_pkg::ADDR_STATUS:    rd_mux = {30'd0, done, busy};
			oflow_reg_pkg::ADDR_MATCH_MAP: rd_mux = match_map;
			oflow_reg_pkg::ADDR_MATCH_CNT: rd_mux = {26'd0, match_cnt};
			default:                       rd_mux = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rd_fire)
			r_data <= rd_mux;
	end

	// ----------------------------------------------------------------------
	// configuration
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			cfg <= '0;
		end else begin
			// start bit self clears
			cfg.start <= wr_fire && host_req.aw_addr == oflow_reg_pkg::ADDR_CTRL &&
				host_req.w_strb[0] && host_req.w_data[0];
			if (wr_fire && host_req.aw_addr == oflow_reg_pkg::ADDR_NUM_BOX &&
				host_req.w_strb[0])
				cfg.num_box <= host_req.w_data[5:0];
			if (wr_fire && host_req.aw_addr == oflow_reg_pkg::ADDR_THRESH) begin
				if (host_req.w_strb[0])
					cfg.thresh[7:0] <= host_req.w_data[7:0];
				if (host_req.w_strb[1])
					cfg.thresh[15:8] <= host_req.w_data[15:8];
			end
		end
	end

	// ----------------------------------------------------------------------
	// result collection
	// ----------------------------------------------------------------------

	// keep only pe bits that map onto real boxes of this frame
	always_comb begin
		set_hits = '0;
		for (int i = 0; i < PE_NUM; i++) begin
			set_match[i] = pe_match[i] &&
				(int'(set_index) * PE_NUM + i < int'(cfg.num_box)) &&
				(int'(set_index) * PE_NUM + i < oflow_core_pkg::MAX_BOXES);
			set_hits = set_hits + 6'(set_match[i]);
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy      <= 1'b0;
			done      <= 1'b0;
			match_map <= '0;
			match_cnt <= '0;
		end else if (cfg.start) begin
			busy      <= 1'b1;
			done      <= 1'b0;
			match_map <= '0;
			match_cnt <= '0;
		end else begin
			if (done_registration) begin
				// map cleared at start, so only ones get written
				for (int i = 0; i < PE_NUM; i++) begin
					if (set_match[i])
						match_map[int'(set_index) * PE_NUM + i] <= 1'b1;
				end
				match_cnt <= match_cnt + set_hits;
			end
			if (frame_done) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// set results only arrive while a frame is running
	assert property (@(posedge clk) disable iff (!reset_N)
		done_registration |-> busy);

endmodule

// ==== rtl/oflow_core_fsm_fe.sv ====
/*
 * box intake, set buffer and previous-frame store
 * num_box must be 1 to 32, with PE_NUM 2 a frame holds at most 30 boxes
 */
`timescale 1ns/1ns

module oflow_core_fsm_fe #(
	parameter  int PE_NUM = 4,
	localparam int CW     = $clog2(PE_NUM + 1)
) (
	input  logic                                  clk,
	input  logic                                  reset_N,
	input  oflow_reg_pkg::cfg_t                   cfg,
	input  logic                                  box_valid,
	input  oflow_core_pkg::bbox_t                 box_data,
	output logic                                  box_ready,
	output logic                                  done_fe,
	output oflow_core_pkg::set_cnt_t              num_of_sets,
	output logic [CW-1:0]                         counter_of_remain_bboxes,
	input  logic                                  done_registration,
	output oflow_core_pkg::bbox_t [PE_NUM-1:0]    cur_box,
	output oflow_core_pkg::bbox_t [PE_NUM-1:0]    prev_box
);

	logic          in_frame;
	logic          set_wait;
	logic [5:0]    box_cnt;
	logic [5:0]    set_base;
	logic [CW-1:0] fill;
	logic          accept;
	logic          last_box;
	logic          set_close;

	oflow_core_pkg::bbox_t prev_store [oflow_core_pkg::MAX_BOXES];

	// stream closed outside a frame and while a set is registered
	assign box_ready = in_frame && !set_wait;
	assign accept    = box_valid && box_ready;
	assign last_box  = (box_cnt + 6'd1 == cfg.num_box);
	// set full or frame complete
	assign set_close = accept && (fill == CW'(PE_NUM - 1) || last_box);

	// set count and size of the last, maybe partial, set
	always_comb begin
		int sets;
		sets = (int'(cfg.num_box) + PE_NUM - 1) / PE_NUM;
		num_of_sets = oflow_core_pkg::set_cnt_t'(sets);
		counter_of_remain_bboxes = CW'(int'(cfg.num_box) - (sets - 1) * PE_NUM);
	end

	// ----------------------------------------------------------------------
	// intake control
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			in_frame <= 1'b0;
			set_wait <= 1'b0;
			box_cnt  <= '0;
			set_base <= '0;
			fill     <= '0;
			done_fe  <= 1'b0;
		end else begin
			done_fe <= set_close;
			if (cfg.start) begin
				in_frame <= 1'b1;
				set_wait <= 1'b0;
				box_cnt  <= '0;
				set_base <= '0;
				fill     <= '0;
			end else if (accept) begin
				box_cnt  <= box_cnt + 6'd1;
				fill     <= fill + 1'b1;
				set_wait <= set_close;
			end else if (done_registration) begin
				// next set starts PE_NUM boxes further on
				set_wait <= 1'b0;
				fill     <= '0;
				set_base <= set_base + 6'(PE_NUM);
				in_frame <= (box_cnt != cfg.num_box);
			end
		end
	end

	// set buffer, slot chosen by fill level
	always_ff @(posedge clk) begin
		if (accept)
			cur_box[fill] <= box_data;
	end

	// ----------------------------------------------------------------------
	// previous-frame store
	// ----------------------------------------------------------------------

	// all zero after reset, so the first frame never matches
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < oflow_core_pkg::MAX_BOXES; i++)
				prev_store[i] <= '0;
		end else if (done_registration) begin
			for (int i = 0; i < PE_NUM; i++) begin
				if (i < int'(fill) && int'(set_base) + i < oflow_core_pkg::MAX_BOXES)
					prev_store[oflow_core_pkg::box_idx_t'(int'(set_base) + i)] <= cur_box[i];
			end
		end
	end

	// entries with the same index as the open set
	always_comb begin
		for (int i = 0; i < PE_NUM; i++) begin
			prev_box[i] = '0;
			if (int'(set_base) + i < oflow_core_pkg::MAX_BOXES)
				prev_box[i] = prev_store[oflow_core_pkg::box_idx_t'(int'(set_base) + i)];
		end
	end

endmodule

// ==== rtl/oflow_core_fsm_registration.sv ====
/*
 * per-set registration control, starts the PEs and waits for all of them
 * the set counter wraps to zero after the last set of a frame
 */
`timescale 1ns/1ns

module oflow_core_fsm_registration #(
	parameter  int PE_NUM = 4,
	localparam int CW     = $clog2(PE_NUM + 1)
) (
	input  logic                     clk,
	input  logic                     reset_N,
	input  oflow_core_pkg::set_cnt_t num_of_sets,
	input  logic [CW-1:0]            counter_of_remain_bboxes,
	input  logic                     done_fe,
	output logic                     done_registration,
	output logic                     frame_done,
	output logic [PE_NUM-1:0]        start_registration,
	input  logic [PE_NUM-1:0]        done_registration_i,
	output oflow_core_pkg::set_cnt_t counter_set_registration
);

	typedef enum logic [1:0] {
		IDLE_ST,
		REGISTRATION_ST,
		WAIT_ST
	} state_t;

	state_t            state;
	state_t            next_state;
	logic              last_set;
	logic              all_done;
	logic [PE_NUM-1:0] pe_mask;

	assign last_set = (counter_set_registration == num_of_sets - 1'b1);

	// last set only uses the low PEs
	always_comb begin
		for (int i = 0; i < PE_NUM; i++)
			pe_mask[i] = !last_set || (i < int'(counter_of_remain_bboxes));
	end

	// idle PEs still hold done from an earlier set, so mask them out
	assign all_done = (done_registration_i & pe_mask) == pe_mask;

	// ----------------------------------------------------------------------
	// next state
	// ----------------------------------------------------------------------
	always_comb begin
		next_state         = state;
		start_registration = '0;
		case (state)
			IDLE_ST: begin
				if (done_fe)
					next_state = REGISTRATION_ST;
			end
			REGISTRATION_ST: begin
				// one cycle start pulse
				start_registration = pe_mask;
				next_state         = WAIT_ST;
			end
			WAIT_ST: begin
				if (all_done)
					next_state = IDLE_ST;
			end
			default: next_state = IDLE_ST;
		endcase
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state                    <= IDLE_ST;
			done_registration        <= 1'b0;
			frame_done               <= 1'b0;
			counter_set_registration <= '0;
		end else begin
			state             <= next_state;
			done_registration <= (state == WAIT_ST) && all_done;
			frame_done        <= (state == WAIT_ST) && all_done && last_set;
			// counter moves after the pulse, so it names the finished set
			if (done_registration)
				counter_set_registration <= frame_done ? '0 : counter_set_registration + 1'b1;
		end
	end

	// a PE is not restarted before it has reported done
	for (genvar g = 0; g < PE_NUM; g++) begin : g_chk
		assert property (@(posedge clk) disable iff (!reset_N)
			start_registration[g] |=> !start_registration[g] until done_registration_i[g]);
	end

endmodule

// ==== rtl/oflow_core_pkg.sv ====
/*
 * data path types of the box registration stage
 * coordinates are unsigned, right and bottom edges need one extra bit
 */
package oflow_core_pkg;

	// one coordinate or extent in pixels
	typedef logic [7:0] coord_t;

	// box corner plus size, edges at x+w and y+h
	typedef struct packed {
		coord_t x;
		coord_t y;
		coord_t w;
		coord_t h;
	} bbox_t;

	// intersection area, at most 255*255
	typedef logic [15:0] area_t;

	// box position inside one frame
	typedef logic [4:0] box_idx_t;

	// set counter and sets per frame
	typedef logic [3:0] set_cnt_t;

	// frame capacity of the previous-frame store
	localparam int MAX_BOXES = 32;

endpackage

// ==== rtl/oflow_core_top.sv ====
/*
 * box registration stage top, host registers plus box stream
 * PE_NUM from 2 to 8
 */
`timescale 1ns/1ns

module oflow_core_top #(
	parameter int PE_NUM = 4
) (
	input  logic                     clk,
	input  logic                     reset_N,
	input  oflow_reg_pkg::axil_req_t host_req,
	output oflow_reg_pkg::axil_rsp_t host_rsp,
	input  logic                     box_valid,
	input  oflow_core_pkg::bbox_t    box_data,
	output logic                     box_ready
);

	localparam int CW = $clog2(PE_NUM + 1);

	oflow_reg_pkg::cfg_t                cfg;
	logic                               done_fe;
	logic                               done_registration;
	logic                               frame_done;
	oflow_core_pkg::set_cnt_t           num_of_sets;
	oflow_core_pkg::set_cnt_t           set_index;
	logic [CW-1:0]                      remain_bboxes;
	logic [PE_NUM-1:0]                  start_registration;
	logic [PE_NUM-1:0]                  pe_done;
	logic [PE_NUM-1:0]                  pe_match;
	oflow_core_pkg::bbox_t [PE_NUM-1:0] cur_box;
	oflow_core_pkg::bbox_t [PE_NUM-1:0] prev_box;

	oflow_axil_regs #(.PE_NUM(PE_NUM)) i_regs (
		.clk               (clk),
		.reset_N           (reset_N),
		.host_req          (host_req),
		.host_rsp          (host_rsp),
		.cfg               (cfg),
		.pe_match          (pe_match),
		.set_index         (set_index),
		.done_registration (done_registration),
		.frame_done        (frame_done)
	);

	oflow_core_fsm_fe #(.PE_NUM(PE_NUM)) i_fe (
		.clk                      (clk),
		.reset_N                  (reset_N),
		.cfg                      (cfg),
		.box_valid                (box_valid),
		.box_data                 (box_data),
		.box_ready                (box_ready),
		.done_fe                  (done_fe),
		.num_of_sets              (num_of_sets),
		.counter_of_remain_bboxes (remain_bboxes),
		.done_registration        (done_registration),
		.cur_box                  (cur_box),
		.prev_box                 (prev_box)
	);

	oflow_core_fsm_registration #(.PE_NUM(PE_NUM)) i_fsm (
		.clk                      (clk),
		.reset_N                  (reset_N),
		.num_of_sets              (num_of_sets),
		.counter_of_remain_bboxes (remain_bboxes),
		.done_fe                  (done_fe),
		.done_registration        (done_registration),
		.frame_done               (frame_done),
		.start_registration       (start_registration),
		.done_registration_i      (pe_done),
		.counter_set_registration (set_index)
	);

	// one PE per slot of the set
	for (genvar g = 0; g < PE_NUM; g++) begin : g_pe
		oflow_registration_pe i_pe (
			.clk      (clk),
			.reset_N  (reset_N),
			.start    (start_registration[g]),
			.cur_box  (cur_box[g]),
			.prev_box (prev_box[g]),
			.thresh   (cfg.thresh),
			.done     (pe_done[g]),
			.match    (pe_match[g])
		);
	end

endmodule

// ==== rtl/oflow_reg_pkg.sv ====
/*
 * host register map, AXI4-Lite channel bundles and configuration
 * all accesses are full 32 bit words, responses are always OKAY
 */
package oflow_reg_pkg;

	// byte offsets
	localparam logic [7:0] ADDR_CTRL      = 8'h00;
	localparam logic [7:0] ADDR_NUM_BOX   = 8'h04;
	localparam logic [7:0] ADDR_THRESH    = 8'h08;
	localparam logic [7:0] ADDR_STATUS    = 8'h0C;
	localparam logic [7:0] ADDR_MATCH_MAP = 8'h10;
	localparam logic [7:0] ADDR_MATCH_CNT = 8'h14;

	// manager to subordinate
	typedef struct packed {
		logic        aw_valid;
		logic [7:0]  aw_addr;
		logic        w_valid;
		logic [31:0] w_data;
		logic [3:0]  w_strb;
		logic        b_ready;
		logic        ar_valid;
		logic [7:0]  ar_addr;
		logic        r_ready;
	} axil_req_t;

	// subordinate to manager
	typedef struct packed {
		logic        aw_ready;
		logic        w_ready;
		logic        b_valid;
		logic [1:0]  b_resp;
		logic        ar_ready;
		logic        r_valid;
		logic [31:0] r_data;
		logic [1:0]  r_resp;
	} axil_rsp_t;

	// frame setup seen by the data path, start is one cycle wide
	typedef struct packed {
		logic [5:0]            num_box;
		oflow_core_pkg::area_t thresh;
		logic                  start;
	} cfg_t;

endpackage

// ==== rtl/oflow_registration_pe.sv ====
/*
 * one registration PE, overlap area by serial shift-add multiply
 * done comes 10 cycles after start, boxes must stay stable meanwhile
 */
`timescale 1ns/1ns

module oflow_registration_pe (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  start,
	input  oflow_core_pkg::bbox_t cur_box,
	input  oflow_core_pkg::bbox_t prev_box,
	input  oflow_core_pkg::area_t thresh,
	output logic                  done,
	output logic                  match
);

	logic [8:0]             cur_r;
	logic [8:0]             cur_b;
	logic [8:0]             prev_r;
	logic [8:0]             prev_b;
	logic [8:0]             left;
	logic [8:0]             top;
	logic [8:0]             right;
	logic [8:0]             bottom;
	oflow_core_pkg::coord_t ov_w;
	oflow_core_pkg::coord_t ov_h;
	logic                   busy;
	logic [3:0]             step;
	oflow_core_pkg::area_t  mcand;
	oflow_core_pkg::area_t  acc;
	oflow_core_pkg::coord_t mplier;

	// far edges at 9 bits
	assign cur_r  = {1'b0, cur_box.x} + {1'b0, cur_box.w};
	assign cur_b  = {1'b0, cur_box.y} + {1'b0, cur_box.h};
	assign prev_r = {1'b0, prev_box.x} + {1'b0, prev_box.w};
	assign prev_b = {1'b0, prev_box.y} + {1'b0, prev_box.h};

	// intersection rectangle
	assign left   = (cur_box.x > prev_box.x) ? {1'b0, cur_box.x} : {1'b0, prev_box.x};
	assign top    = (cur_box.y > prev_box.y) ? {1'b0, cur_box.y} : {1'b0, prev_box.y};
	assign right  = (cur_r < prev_r) ? cur_r : prev_r;
	assign bottom = (cur_b < prev_b) ? cur_b : prev_b;

	// clamp at zero, otherwise bounded by the smaller extent
	assign ov_w = (right > left) ? oflow_core_pkg::coord_t'(right - left) : '0;
	assign ov_h = (bottom > top) ? oflow_core_pkg::coord_t'(bottom - top) : '0;

	// step 0..7 multiply, step 8 compare
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy  <= 1'b0;
			step  <= '0;
			done  <= 1'b0;
			match <= 1'b0;
		end else if (start) begin
			busy  <= 1'b1;
			step  <= '0;
			done  <= 1'b0;
			match <= 1'b0;
		end else if (busy) begin
			step <= step + 4'd1;
			if (step == 4'd8) begin
				busy  <= 1'b0;
				done  <= 1'b1;
				match <= (acc >= thresh);
			end
		end
	end

	// shift-add, lsb of multiplier first
	always_ff @(posedge clk) begin
		if (start) begin
			acc    <= '0;
			mcand  <= {8'd0, ov_w};
			mplier <= ov_h;
		end else if (busy && step < 4'd8) begin
			if (mplier[0])
				acc <= acc + mcand;
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

endmodule

// ==== verif/oflow_tb_tasks.svh ====
/*
 * testbench helpers, included inside the testbench top module
 * they use its clock, host bundle, box stream and random state directly
 */
`ifndef OFLOW_TB_TASKS_SVH
`define OFLOW_TB_TASKS_SVH

// ----------------------------------------------------------------------
// random numbers and checks
// ----------------------------------------------------------------------

// 32 bit LCG, state lives in the testbench top
function automatic logic [31:0] next_random();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

task automatic check_value(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	if (actual !== expected) begin
		error_count++;
		$display("MISMATCH %s expected 0x%08h actual 0x%08h", name, expected, actual);
		$display("Simulation finished: FAIL");
		$fatal(1, "wrong value seen by check_value");
	end
endtask

// ----------------------------------------------------------------------
// AXI4-Lite host
// ----------------------------------------------------------------------

// aw and w together, response taken right away
task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
	@(posedge clk);
	host_req.aw_valid <= 1'b1;
	host_req.aw_addr  <= addr;
	host_req.w_valid  <= 1'b1;
	host_req.w_data   <= data;
	host_req.w_strb   <= 4'hf;
	host_req.b_ready  <= 1'b1;
	@(negedge clk);
	while (!host_rsp.aw_ready)
		@(negedge clk);
	@(posedge clk);
	host_req.aw_valid <= 1'b0;
	host_req.w_valid  <= 1'b0;
	@(negedge clk);
	while (!host_rsp.b_valid)
		@(negedge clk);
	// every write answers OKAY
	check_value("axil_write_resp", 32'h0, host_rsp.b_resp);
	@(posedge clk);
	host_req.b_ready <= 1'b0;
endtask

task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
	@(posedge clk);
	host_req.ar_valid <= 1'b1;
	host_req.ar_addr  <= addr;
	host_req.r_ready  <= 1'b1;
	@(negedge clk);
	while (!host_rsp.ar_ready)
		@(negedge clk);
	@(posedge clk);
	host_req.ar_valid <= 1'b0;
	@(negedge clk);
	while (!host_rsp.r_valid)
		@(negedge clk);
	// data held with r_valid
	data = host_rsp.r_data;
	// OKAY also for unmapped offsets
	check_value("axil_read_resp", 32'h0, host_rsp.r_resp);
	@(posedge clk);
	host_req.r_ready <= 1'b0;
endtask

// ----------------------------------------------------------------------
// box stream
// ----------------------------------------------------------------------

// valid held until the front end takes the box
task automatic send_box(input oflow_core_pkg::bbox_t box);
	@(posedge clk);
	box_valid <= 1'b1;
	box_data  <= box;
	@(negedge clk);
	while (!box_ready)
		@(negedge clk);
	@(posedge clk);
	box_valid <= 1'b0;
endtask

`endif

// ==== verif/oflow_core_tb.sv ====
/*
 * testbench for the box registration stage with PE_NUM 4
 * keeps its own previous frame, runs stop at the first wrong value
 */
`timescale 1ns/1ns

module oflow_core_tb;

	localparam int PE_NUM = 4;
	// one frame is about 200 cycles of register access, box transfer,
	// registration and status polling, three frames need well under 1000
	localparam int TIMEOUT_CYCLES = 20000;

	logic                     clk;
	logic                     reset_N;
	oflow_reg_pkg::axil_req_t host_req;
	oflow_reg_pkg::axil_rsp_t host_rsp;
	logic                     box_valid;
	oflow_core_pkg::bbox_t    box_data;
	logic                     box_ready;

	logic [31:0] lcg_state;
	int          error_count;
	int          cycle_count;
	int          frames_sent;
	int          frames_checked;
	string       test_name;
	logic [31:0] exp_map;
	logic [31:0] exp_cnt;

	oflow_core_pkg::bbox_t cur_frame  [oflow_core_pkg::MAX_BOXES];
	oflow_core_pkg::bbox_t prev_frame [oflow_core_pkg::MAX_BOXES];

	`include "oflow_tb_tasks.svh"

	oflow_core_top #(.PE_NUM(PE_NUM)) i_dut (
		.clk       (clk),
		.reset_N   (reset_N),
		.host_req  (host_req),
		.host_rsp  (host_rsp),
		.box_valid (box_valid),
		.box_data  (box_data),
		.box_ready (box_ready)
	);

	// 4 ns period
	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$fatal(1, "cycle limit reached");
		end
	end

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------

	// overlap of two boxes, clamped at zero, against the threshold
	function automatic logic ref_match(input oflow_core_pkg::bbox_t cur,
		input oflow_core_pkg::bbox_t prev, input int thresh);
		int left;
		int top;
		int right;
		int bottom;
		int ov_w;
		int ov_h;
		left   = (cur.x > prev.x) ? int'(cur.x) : int'(prev.x);
		top    = (cur.y > prev.y) ? int'(cur.y) : int'(prev.y);
		right  = int'(cur.x) + int'(cur.w);
		bottom = int'(cur.y) + int'(cur.h);
		if (int'(prev.x) + int'(prev.w) < right)
			right = int'(prev.x) + int'(prev.w);
		if (int'(prev.y) + int'(prev.h) < bottom)
			bottom = int'(prev.y) + int'(prev.h);
		ov_w = (right > left) ? right - left : 0;
		ov_h = (bottom > top) ? bottom - top : 0;
		return (ov_w * ov_h >= thresh);
	endfunction

	// expected result first, then the frame, then wait for the compare
	task automatic run_frame(input string name, input int num, input int thresh);
		logic [31:0] map;
		int          cnt;
		map = '0;
		cnt = 0;
		for (int i = 0; i < num; i++) begin
			if (ref_match(cur_frame[i], prev_frame[i], thresh)) begin
				map[i] = 1'b1;
				cnt++;
			end
		end
		test_name = name;
		exp_map   = map;
		exp_cnt   = cnt;
		axil_write(oflow_reg_pkg::ADDR_NUM_BOX, num);
		axil_write(oflow_reg_pkg::ADDR_THRESH, thresh);
		axil_write(oflow_reg_pkg::ADDR_CTRL, 32'h1);
		for (int i = 0; i < num; i++)
			send_box(cur_frame[i]);
		frames_sent++;
		wait (frames_checked == frames_sent);
		// this frame becomes the stored one
		for (int i = 0; i < num; i++)
			prev_frame[i] = cur_frame[i];
	endtask

	// ----------------------------------------------------------------------
	// comparison
	// ----------------------------------------------------------------------
	initial begin : compare_results
		logic [31:0] status;
		logic [31:0] map;
		logic [31:0] cnt;
		forever begin
			wait (frames_sent > frames_checked);
			// poll until the frame is marked done
			status = '0;
			while (!status[1])
				axil_read(oflow_reg_pkg::ADDR_STATUS, status);
			check_value({test_name, "_status"}, 32'h2, status);
			axil_read(oflow_reg_pkg::ADDR_MATCH_MAP, map);
			axil_read(oflow_reg_pkg::ADDR_MATCH_CNT, cnt);
			// all 32 bits, so bits past the frame must stay zero
			check_value({test_name, "_map"}, exp_map, map);
			check_value({test_name, "_count"}, exp_cnt, cnt);
			frames_checked++;
		end
	end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	initial begin : stimulus
		logic [31:0]           rd;
		oflow_core_pkg::bbox_t box;
		int                    jx;
		int                    jy;
		host_req    = '0;
		box_valid   = 1'b0;
		box_data    = '0;
		reset_N     = 1'b0;
		lcg_state   = 32'ha3a1_94cf;
		error_count = 0;
		cycle_count = 0;
		for (int i = 0; i < oflow_core_pkg::MAX_BOXES; i++) begin
			prev_frame[i] = '0;
			cur_frame[i]  = '0;
		end
		repeat (5) @(posedge clk);
		reset_N <= 1'b1;

		// idle after reset, stream closed without start
		axil_read(oflow_reg_pkg::ADDR_STATUS, rd);
		check_value("reset_status", 32'h0, rd);
		axil_write(oflow_reg_pkg::ADDR_NUM_BOX, 32'd8);
		repeat (8) begin
			@(negedge clk);
			check_value("ready_before_start", 32'h0, box_ready);
		end

		// random boxes, one of them with zero height
		for (int i = 0; i < 8; i++)
			cur_frame[i] = next_random();
		cur_frame[5].h = 8'd0;
		run_frame("first_frame", 8, 1);
		run_frame("repeat_frame", 8, 1);

		// small position jitter, extents kept
		// last set has three boxes, PE 3 keeps its match from the frame before
		for (int i = 0; i < 7; i++) begin
			box = prev_frame[i];
			jx  = int'(box.x) + int'(next_random() % 9) - 4;
			jy  = int'(box.y) + int'(next_random() % 9) - 4;
			jx  = (jx < 0) ? 0 : (jx > 255) ? 255 : jx;
			jy  = (jy < 0) ? 0 : (jy > 255) ? 255 : jy;
			box.x = jx[7:0];
			box.y = jy[7:0];
			cur_frame[i] = box;
		end
		run_frame("jitter_frame", 7, 1 + int'(next_random() % 16384));

		// register read back and an unmapped offset
		axil_write(oflow_reg_pkg::ADDR_NUM_BOX, 32'h0000_002a);
		axil_read(oflow_reg_pkg::ADDR_NUM_BOX, rd);
		check_value("num_box_readback", 32'h0000_002a, rd);
		axil_write(oflow_reg_pkg::ADDR_THRESH, 32'h0000_beef);
		axil_read(oflow_reg_pkg::ADDR_THRESH, rd);
		check_value("thresh_readback", 32'h0000_beef, rd);
		axil_write(8'h20, 32'hdead_beef);
		axil_read(8'h20, rd);
		check_value("unknown_addr_readback", 32'h0, rd);

		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+verif
rtl/oflow_core_pkg.sv
rtl/oflow_reg_pkg.sv
rtl/oflow_axil_regs.sv
rtl/oflow_core_fsm_fe.sv
rtl/oflow_core_fsm_registration.sv
rtl/oflow_registration_pe.sv
rtl/oflow_core_top.sv
verif/oflow_core_tb.sv
